//--- hw/ifu_cfg_pkg.sv
/*
 * Fetch unit configuration
 * Reset address and fetch buffer geometry
 */

`default_nettype none

package ifu_cfg_pkg;

   // ******************************************************************
   // Reset state
   // ******************************************************************

   // Halfword address, pc bits 31:1
   localparam logic [30:0] RESET_PC = 31'h0000_0000;

   // ******************************************************************
   // Fetch buffer
   // ******************************************************************

   // Word entries, must be a power of two
   localparam int FETCH_BUF_DEPTH = 4;

   // Read and write pointer width
   localparam int FETCH_BUF_PTR_W = $clog2(FETCH_BUF_DEPTH);

   // The occupancy count carries one extra bit above the pointers,
   // so a full buffer shows up as the top count bit alone

endpackage

`default_nettype wire

//--- hw/ifu_types_pkg.sv
/*
 * Fetch unit data types
 * Addresses, fetch words, parcels and decode instructions
 */

`default_nettype none

package ifu_types_pkg;

   // ******************************************************************
   // Addresses
   // ******************************************************************

   // Word address, pc bits 31:2
   typedef logic [29:0] word_addr_t;

   // Halfword pc, pc bits 31:1
   typedef logic [30:0] half_addr_t;

   // ******************************************************************
   // Instruction data
   // ******************************************************************

   // One 32-bit word as returned by instruction memory
   typedef logic [31:0] fetch_word_t;

   // One 16-bit parcel
   // Low two bits 2'b11 marks the first half of a 32-bit instruction
   typedef logic [15:0] parcel_t;

   // Instruction to decode
   // Compressed ones sit in the low half with the upper half zero
   typedef logic [31:0] instr_t;

endpackage

`default_nettype wire

//--- hw/fetch_if.sv
/*
 * Fetch word channel between pipeline stages
 * One word with its address and a skip flag for the low parcel
 */

`timescale 1ns/100ps
`default_nettype none

interface fetch_if;

   logic                       valid;    // Word offered
   logic                       ready;    // Word taken by receiver
   ifu_types_pkg::fetch_word_t data;     // Raw fetch data
   ifu_types_pkg::word_addr_t  word_pc;  // Address of data
   logic                       skip_lo;  // Low parcel precedes redirect target

   // Sender side
   modport src (
      output valid,
      input  ready,
      output data,
      output word_pc,
      output skip_lo
   );

   // Receiver side
   modport dst (
      input  valid,
      output ready,
      input  data,
      input  word_pc,
      input  skip_lo
   );

endinterface

`default_nettype wire

//--- hw/ifu_fetch_ctl.sv
/*
 * Fetch controller
 * Sequences word addresses, redirects on flush and runs the
 * four-phase request to instruction memory
 */

`timescale 1ns/100ps
`default_nettype none

module ifu_fetch_ctl (
   input  wire logic                       clk,
   input  wire logic                       rst,
   input  wire logic                       flush,
   input  wire ifu_types_pkg::half_addr_t  flush_pc,
   output logic                            mem_req,
   output ifu_types_pkg::word_addr_t       mem_addr,
   input  wire logic                       mem_ack,
   input  wire ifu_types_pkg::fetch_word_t mem_rdata,
   fetch_if.src                            fetch_out
);

   typedef enum logic [1:0] {
      S_IDLE,     // No handshake open
      S_REQ,      // Request up, waiting for ack
      S_ACK_LOW   // Request down, waiting for ack release
   } fsm_t;

   fsm_t                       state;
   ifu_types_pkg::word_addr_t  next_addr;   // Next word to request
   logic                       pend_skip;   // Next word starts on odd halfword
   ifu_types_pkg::word_addr_t  req_addr;    // Address of open request
   logic                       req_skip;
   logic                       squash;      // Open request belongs to old stream
   logic                       hold_valid;
   ifu_types_pkg::fetch_word_t hold_data;
   ifu_types_pkg::word_addr_t  hold_pc;
   logic                       hold_skip;
   logic                       start;
   logic                       capture;

   // ******************************************************************
   // Handshake control
   // ******************************************************************

   assign start   = (state == S_IDLE) && !hold_valid && !mem_ack && !flush;
   assign capture = (state == S_REQ) && mem_ack;  // Data valid with ack

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= S_IDLE;
         next_addr  <= ifu_cfg_pkg::RESET_PC[30:1];
         pend_skip  <= ifu_cfg_pkg::RESET_PC[0];
         squash     <= 1'b0;
         hold_valid <= 1'b0;
      end else begin
         case (state)
            S_IDLE:    if (start) state <= S_REQ;
            S_REQ:     if (mem_ack) state <= S_ACK_LOW;   // Drop req after ack
            S_ACK_LOW: if (!mem_ack) state <= S_IDLE;
            default:   state <= S_IDLE;
         endcase

         if (flush) begin
            next_addr <= flush_pc[30:1];  // Redirect
            pend_skip <= flush_pc[0];     // Odd halfword target
         end else if (start) begin
            next_addr <= next_addr + 1'b1;
            pend_skip <= 1'b0;
         end

         // A word still in flight at flush comes back stale
         if (flush)
            squash <= (state == S_REQ) && !mem_ack;
         else if (capture)
            squash <= 1'b0;

         if (flush)
            hold_valid <= 1'b0;
         else if (capture && !squash)
            hold_valid <= 1'b1;
         else if (fetch_out.valid && fetch_out.ready)
            hold_valid <= 1'b0;
      end
   end

   // Request and holding payload
   always_ff @(posedge clk) begin
      if (start) begin
         req_addr <= next_addr;
         req_skip <= pend_skip;
      end
      if (capture) begin
         hold_data <= mem_rdata;
         hold_pc   <= req_addr;
         hold_skip <= req_skip;
      end
   end

   assign mem_req  = (state == S_REQ);
   assign mem_addr = req_addr;  // Held for the whole request

   assign fetch_out.valid   = hold_valid;
   assign fetch_out.data    = hold_data;
   assign fetch_out.word_pc = hold_pc;
   assign fetch_out.skip_lo = hold_skip;

   // Request must stay up until the memory acknowledges
   req_held_to_ack: assert property (
      @(posedge clk) disable iff (rst) $fell(mem_req) |-> $past(mem_ack)
   );

endmodule

`default_nettype wire

//--- hw/ifu_fetch_buf.sv
/*
 * Fetch buffer
 * Circular FIFO of fetched words between fetch control and aligner
 */

`timescale 1ns/100ps
`default_nettype none

module ifu_fetch_buf (
   input  wire logic clk,
   input  wire logic rst,
   input  wire logic flush,
   fetch_if.dst      fetch_in,
   fetch_if.src      fetch_out
);

   // ******************************************************************
   // Storage
   // ******************************************************************

   ifu_types_pkg::fetch_word_t data_mem [ifu_cfg_pkg::FETCH_BUF_DEPTH];
   ifu_types_pkg::word_addr_t  pc_mem   [ifu_cfg_pkg::FETCH_BUF_DEPTH];
   logic                       skip_mem [ifu_cfg_pkg::FETCH_BUF_DEPTH];

   logic [ifu_cfg_pkg::FETCH_BUF_PTR_W-1:0] wr_ptr;
   logic [ifu_cfg_pkg::FETCH_BUF_PTR_W-1:0] rd_ptr;
   logic [ifu_cfg_pkg::FETCH_BUF_PTR_W:0]   count;   // One bit wider than ptrs
   logic                                    full;
   logic                                    empty;
   logic                                    push;
   logic                                    pop;

   assign full  = count[ifu_cfg_pkg::FETCH_BUF_PTR_W];  // Depth is a power of two
   assign empty = (count == '0);
   assign push  = fetch_in.valid && fetch_in.ready;
   assign pop   = fetch_out.valid && fetch_out.ready;

   // Write side, no reset on entries
   always_ff @(posedge clk) begin
      if (push) begin
         data_mem[wr_ptr] <= fetch_in.data;
         pc_mem[wr_ptr]   <= fetch_in.word_pc;
         skip_mem[wr_ptr] <= fetch_in.skip_lo;
      end
   end

   // ******************************************************************
   // Pointers and occupancy
   // ******************************************************************

   always_ff @(posedge clk) begin
      if (rst || flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;   // Flush drops everything in flight
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   assign fetch_in.ready = !full;

   // Head entry visible the cycle after its push
   assign fetch_out.valid   = !empty;
   assign fetch_out.data    = data_mem[rd_ptr];
   assign fetch_out.word_pc = pc_mem[rd_ptr];
   assign fetch_out.skip_lo = skip_mem[rd_ptr];

   // Word refused by a full buffer stays offered unchanged
   held_while_full: assert property (
      @(posedge clk) disable iff (rst)
      (fetch_in.valid && !fetch_in.ready && !flush) |=>
         (fetch_in.valid && $stable(fetch_in.data) && $stable(fetch_in.word_pc) &&
          $stable(fetch_in.skip_lo))
   );

endmodule

`default_nettype wire

//--- hw/ifu_aligner.sv
/*
 * Instruction aligner
 * Splits the word stream into compressed and 32-bit instructions,
 * including ones that straddle two words
 */

`timescale 1ns/100ps
`default_nettype none

module ifu_aligner (
   input  wire logic                 clk,
   input  wire logic                 rst,
   input  wire logic                 flush,
   fetch_if.dst                      fetch_in,
   output logic                      instr_valid,
   input  wire logic                 instr_ready,
   output ifu_types_pkg::instr_t     instr,
   output ifu_types_pkg::half_addr_t instr_pc,
   output logic                      instr_pc4
);

   logic                      res_valid;   // Residual parcel held
   ifu_types_pkg::parcel_t    res_parcel;
   ifu_types_pkg::half_addr_t res_pc;
   ifu_types_pkg::parcel_t    lo;
   ifu_types_pkg::parcel_t    hi;
   logic                      can_load;    // Output register free this cycle
   logic                      emit;        // Instruction complete
   logic                      take;        // Word consumed
   logic                      stash;       // High parcel kept as residual
   ifu_types_pkg::instr_t     new_instr;
   ifu_types_pkg::half_addr_t new_pc;
   logic                      new_pc4;

   // First parcel of a 32-bit instruction
   function automatic logic is_wide(input ifu_types_pkg::parcel_t p);
      return p[1:0] == 2'b11;
   endfunction

   assign lo       = fetch_in.data[15:0];
   assign hi       = fetch_in.data[31:16];
   assign can_load = !instr_valid || instr_ready;

   // ******************************************************************
   // Parcel selection
   // ******************************************************************

   always_comb begin
      emit      = 1'b0;
      take      = 1'b0;
      stash     = 1'b0;
      new_instr = '0;
      new_pc    = res_pc;
      new_pc4   = 1'b0;
      if (res_valid) begin
         if (!is_wide(res_parcel)) begin
            emit      = 1'b1;   // Residual alone, word left in place
            new_instr = {16'h0000, res_parcel};
         end else if (fetch_in.valid) begin
            emit      = 1'b1;   // Straddles into this word
            take      = 1'b1;
            stash     = 1'b1;
            new_instr = {lo, res_parcel};
            new_pc4   = 1'b1;
         end
      end else if (fetch_in.valid) begin
         take = 1'b1;
         if (fetch_in.skip_lo) begin
            new_pc = {fetch_in.word_pc, 1'b1};  // Redirect into high half
            if (is_wide(hi)) begin
               stash = 1'b1;                    // Wait for next word
            end else begin
               emit      = 1'b1;
               new_instr = {16'h0000, hi};
            end
         end else if (!is_wide(lo)) begin
            emit      = 1'b1;
            stash     = 1'b1;   // High parcel goes next
            new_instr = {16'h0000, lo};
            new_pc    = {fetch_in.word_pc, 1'b0};
         end else begin
            emit      = 1'b1;   // Aligned full word
            new_instr = fetch_in.data;
            new_pc    = {fetch_in.word_pc, 1'b0};
            new_pc4   = 1'b1;
         end
      end
   end

   assign fetch_in.ready = take && can_load;

   // ******************************************************************
   // Residual and output registers
   // ******************************************************************

   always_ff @(posedge clk) begin
      if (rst || flush) begin
         res_valid   <= 1'b0;
         instr_valid <= 1'b0;
      end else if (can_load) begin
         instr_valid <= emit;
         if (stash)
            res_valid <= 1'b1;
         else if (emit)
            res_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (can_load && stash) begin
         res_parcel <= hi;
         res_pc     <= {fetch_in.word_pc, 1'b1};
      end
      if (can_load && emit) begin
         instr     <= new_instr;
         instr_pc  <= new_pc;
         instr_pc4 <= new_pc4;
      end
   end

   // Stalled output holds until decode takes it
   hold_on_stall: assert property (
      @(posedge clk) disable iff (rst)
      (instr_valid && !instr_ready && !flush) |=>
         (instr_valid && $stable(instr) && $stable(instr_pc) && $stable(instr_pc4))
   );

endmodule

`default_nettype wire

//--- hw/ifu_top.sv
/*
 * Instruction fetch unit top level
 * Fetch control, fetch buffer and aligner in a chain
 */

`timescale 1ns/100ps
`default_nettype none

module ifu_top (
   input  wire logic                       clk,
   input  wire logic                       rst,
   input  wire logic                       flush,
   input  wire ifu_types_pkg::half_addr_t  flush_pc,
   output logic                            mem_req,
   output ifu_types_pkg::word_addr_t       mem_addr,
   input  wire logic                       mem_ack,
   input  wire ifu_types_pkg::fetch_word_t mem_rdata,
   output logic                            instr_valid,
   input  wire logic                       instr_ready,
   output ifu_types_pkg::instr_t           instr,
   output ifu_types_pkg::half_addr_t       instr_pc,
   output logic                            instr_pc4
);

   fetch_if ctl_to_buf ();   // Holding register to FIFO
   fetch_if buf_to_aln ();   // FIFO head to aligner

   ifu_fetch_ctl fetch_ctl_inst (
      .clk       (clk),
      .rst       (rst),
      .flush     (flush),
      .flush_pc  (flush_pc),
      .mem_req   (mem_req),
      .mem_addr  (mem_addr),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata),
      .fetch_out (ctl_to_buf.src)
   );

   ifu_fetch_buf fetch_buf_inst (
      .clk       (clk),
      .rst       (rst),
      .flush     (flush),
      .fetch_in  (ctl_to_buf.dst),
      .fetch_out (buf_to_aln.src)
   );

   ifu_aligner aligner_inst (
      .clk         (clk),
      .rst         (rst),
      .flush       (flush),
      .fetch_in    (buf_to_aln.dst),
      .instr_valid (instr_valid),
      .instr_ready (instr_ready),
      .instr       (instr),
      .instr_pc    (instr_pc),
      .instr_pc4   (instr_pc4)
   );

endmodule

`default_nettype wire

//--- sim/ifu_tb.sv
/*
 * Instruction fetch unit testbench
 * Four-phase memory model, random decode stalls and flushes,
 * with a reference parcel walker checked by assertions
 */

`timescale 1ns/100ps
`default_nettype none

module ifu_tb;

   localparam logic [31:0] SEED        = 32'hcce7_708c;
   localparam int          MEM_LIMIT   = 400;    // Cycles to see a handshake
   localparam int          DRAIN_LIMIT = 4000;   // Cycles to see a batch decoded

   logic                       clk         = 1'b0;
   logic                       rst         = 1'b1;
   logic                       flush       = 1'b0;
   ifu_types_pkg::half_addr_t  flush_pc    = '0;
   logic                       mem_ack     = 1'b0;
   ifu_types_pkg::fetch_word_t mem_rdata   = '0;
   logic                       instr_ready = 1'b0;
   logic                       mem_req;
   ifu_types_pkg::word_addr_t  mem_addr;
   logic                       instr_valid;
   ifu_types_pkg::instr_t      instr;
   ifu_types_pkg::half_addr_t  instr_pc;
   logic                       instr_pc4;

   logic [31:0]               rng         = SEED;   // Memory and stall pattern
   logic                      armed       = 1'b0;   // Ack delay loaded
   int                        ack_wait    = 0;
   logic                      heavy_stall = 1'b0;   // Decode ready one cycle in four
   ifu_types_pkg::half_addr_t exp_pc;               // Walker position
   ifu_types_pkg::word_addr_t last_addr;            // Previous request address
   logic                      seq_first;            // Next request starts a stream
   logic                      first_done;
   logic                      prev_rst, prev_req, prev_ack, prev_flush;
   logic                      prev_valid, prev_ready, prev_pc4;
   ifu_types_pkg::word_addr_t prev_addr;
   ifu_types_pkg::instr_t     prev_instr;
   ifu_types_pkg::half_addr_t prev_pc;
   int                        accepted    = 0;
   int                        flushes     = 0;
   int                        errors      = 0;
   logic                      timed_out   = 1'b0;

   ifu_top ifu_top_inst (.*);

   initial begin
      forever #4 clk = ~clk;   // 8 ns period
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // ********************************************************************
   // Memory image and reference walker
   // ********************************************************************

   // Each halfword hashes to its own parcel, about one in four starts a long one
   function automatic ifu_types_pkg::parcel_t parcel_at(input ifu_types_pkg::half_addr_t h);
      logic [15:0] x;
      x = h[15:0] ^ {h[30:16], 1'b0} ^ 16'h5a3c;
      return x * 16'h9e37;
   endfunction

   function automatic ifu_types_pkg::fetch_word_t image_word(input ifu_types_pkg::word_addr_t a);
      return {parcel_at({a, 1'b1}), parcel_at({a, 1'b0})};   // Low halfword first
   endfunction

   function automatic logic is_long(input ifu_types_pkg::half_addr_t pc);
      ifu_types_pkg::parcel_t p;
      p = parcel_at(pc);
      return p[1:0] == 2'b11;
   endfunction

   function automatic ifu_types_pkg::instr_t expect_instr(input ifu_types_pkg::half_addr_t pc);
      if (is_long(pc))
         return {parcel_at(pc + 1'b1), parcel_at(pc)};   // May cross a word
      return {16'h0000, parcel_at(pc)};
   endfunction

   task automatic flag_mismatch(input string name, input logic [31:0] got, input logic [31:0] want);
      errors++;
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, want);
   endtask

   task automatic note_failure(input string what);
      errors++;
      $display("Check failed: %s", what);
   endtask

   // Memory responder with random ack delay, decode ready pattern
   always @(posedge clk) begin
      rng = xorshift(rng);
      instr_ready <= heavy_stall ? (rng[3:2] == 2'b00) : rng[3];
      if (rst) begin
         mem_ack <= 1'b0;
         armed   <= 1'b0;
      end else if (mem_ack) begin
         if (!mem_req)
            mem_ack <= 1'b0;   // Phase 4
      end else if (mem_req) begin
         if (!armed) begin
            armed    <= 1'b1;
            ack_wait <= rng % 6;
         end else if (ack_wait == 0) begin
            armed     <= 1'b0;
            mem_ack   <= 1'b1;
            mem_rdata <= image_word(mem_addr);
         end else begin
            ack_wait <= ack_wait - 1;
         end
      end
   end

   // ********************************************************************
   // Protocol, stall and stream checks
   // ********************************************************************

   always @(posedge clk) begin : monitor
      ifu_types_pkg::word_addr_t next_req;
      next_req = last_addr + 1'b1;
      if (rst) begin
         exp_pc     <= ifu_cfg_pkg::RESET_PC;
         seq_first  <= 1'b1;
         first_done <= 1'b0;
      end else begin
         if (prev_rst)
            assert (!mem_req && !instr_valid)
               else note_failure("mem_req or instr_valid high right after reset");
         if (prev_req && !mem_req)
            assert (prev_ack) else note_failure("mem_req dropped before mem_ack rose");
         if (prev_req && mem_req)
            assert (mem_addr == prev_addr) else flag_mismatch("mem_addr", mem_addr, prev_addr);
         if (mem_req && !prev_req) begin
            assert (!mem_ack) else note_failure("mem_req rose while mem_ack was high");
            if (!seq_first)
               assert (mem_addr == next_req) else flag_mismatch("mem_addr", mem_addr, next_req);
            last_addr <= mem_addr;
            seq_first <= 1'b0;
         end
         if (prev_valid && !prev_ready && !prev_flush) begin
            assert (instr_valid) else note_failure("instr_valid fell during a decode stall");
            assert (instr == prev_instr) else flag_mismatch("instr", instr, prev_instr);
            assert (instr_pc == prev_pc) else flag_mismatch("instr_pc", instr_pc, prev_pc);
            assert (instr_pc4 == prev_pc4) else flag_mismatch("instr_pc4", instr_pc4, prev_pc4);
         end
         if (flush) begin
            exp_pc    <= flush_pc;   // Walker restarts at the target
            seq_first <= 1'b1;
         end else if (instr_valid && instr_ready) begin
            if (!first_done)
               assert (instr_pc == ifu_cfg_pkg::RESET_PC)
                  else flag_mismatch("instr_pc", instr_pc, ifu_cfg_pkg::RESET_PC);
            assert (instr_pc == exp_pc) else flag_mismatch("instr_pc", instr_pc, exp_pc);
            assert (instr == expect_instr(exp_pc))
               else flag_mismatch("instr", instr, expect_instr(exp_pc));
            assert (instr_pc4 == is_long(exp_pc))
               else flag_mismatch("instr_pc4", instr_pc4, is_long(exp_pc));
            exp_pc     <= exp_pc + (is_long(exp_pc) ? 31'd2 : 31'd1);
            first_done <= 1'b1;
            accepted   <= accepted + 1;
         end
      end
      prev_rst   <= rst;
      prev_req   <= mem_req;
      prev_ack   <= mem_ack;
      prev_addr  <= mem_addr;
      prev_flush <= flush;
      prev_valid <= instr_valid;
      prev_ready <= instr_ready;
      prev_instr <= instr;
      prev_pc    <= instr_pc;
      prev_pc4   <= instr_pc4;
   end

   task automatic await_instructions(input int target);
      int cycles;
      cycles = 0;
      if (!timed_out) begin
         while (accepted < target && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
         end
         if (accepted < target) begin
            timed_out = 1'b1;
            $display("Timeout: decode took %0d of %0d instructions", accepted, target);
         end
      end
   endtask

   task automatic sync_to_handshake(input logic on_ack);
      int cycles;
      cycles = 0;
      if (!timed_out) begin
         do begin
            @(posedge clk);
            cycles++;
         end while (!(on_ack ? mem_ack : mem_req) && cycles < MEM_LIMIT);
         if (!(on_ack ? mem_ack : mem_req)) begin
            timed_out = 1'b1;
            $display("Timeout: no memory %s seen", on_ack ? "ack" : "request");
         end
      end
   endtask

   initial begin : main
      logic [31:0] frng;
      frng = xorshift(SEED);
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      await_instructions(200);
      // Flush with a request open, then with the ack already up
      for (int i = 0; i < 6; i++) begin
         sync_to_handshake(i[0]);
         frng = xorshift(frng);
         flush    <= 1'b1;
         flush_pc <= {frng[30:1], 1'b1};   // Odd halfword target
         @(posedge clk);
         flush <= 1'b0;
         flushes++;
         await_instructions(accepted + 40);
      end
      heavy_stall <= 1'b1;
      await_instructions(accepted + 200);
      @(negedge clk);
      $display("Checked %0d instructions across %0d flushes, %0d errors, timeout %0d",
               accepted, flushes, errors, timed_out);
      if (errors == 0 && !timed_out)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
hw/ifu_cfg_pkg.sv
hw/ifu_types_pkg.sv
hw/fetch_if.sv
hw/ifu_fetch_ctl.sv
hw/ifu_fetch_buf.sv
hw/ifu_aligner.sv
hw/ifu_top.sv
sim/ifu_tb.sv

//--- Bender.yml
package:
  name: ifu

sources:
  - hw/ifu_cfg_pkg.sv
  - hw/ifu_types_pkg.sv
  - hw/fetch_if.sv
  - hw/ifu_fetch_ctl.sv
  - hw/ifu_fetch_buf.sv
  - hw/ifu_aligner.sv
  - hw/ifu_top.sv
  - target: test
    files:
      - sim/ifu_tb.sv
